// File: hw/du_pkg.sv
// Debug unit shared definitions
`default_nettype none

package du_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and types
  ////////////////////////////////////////////////////////////////////////////
  localparam int unsigned XLEN            = 32;
  localparam int unsigned DU_ADDR_W       = 8;
  localparam int unsigned MAX_BREAKPOINTS = 8;

  // Exception vector, traps in the low half and interrupts in the high half
  localparam int unsigned EXC_W      = 32;
  localparam int unsigned EXC_TRAP_W = 16;

  typedef logic [XLEN-1:0]      du_word_t;
  typedef logic [DU_ADDR_W-1:0] du_addr_t;

  // Breakpoint conditions, codes 4 to 7 never match
  typedef enum logic [2:0] {
    BP_CC_FETCH    = 3'd0,
    BP_CC_LD_ADR   = 3'd1,
    BP_CC_ST_ADR   = 3'd2,
    BP_CC_LDST_ADR = 3'd3
  } bp_cc_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map and field positions
  ////////////////////////////////////////////////////////////////////////////
  localparam du_addr_t DU_CTRL     = 8'h00;
  localparam du_addr_t DU_HIT      = 8'h01;
  localparam du_addr_t DU_IE       = 8'h02;
  localparam du_addr_t DU_CAUSE    = 8'h03;
  localparam du_addr_t DU_BPCTRL0  = 8'h10;
  localparam du_addr_t DU_BPDATA0  = 8'h11;

  localparam int unsigned CTRL_STEP_BIT   = 0;
  localparam int unsigned CTRL_BRANCH_BIT = 1;
  localparam int unsigned HIT_STEP_BIT    = 0;
  localparam int unsigned HIT_BRANCH_BIT  = 1;
  localparam int unsigned HIT_BP_LSB      = 4;
  localparam int unsigned BPCTRL_IMPL_BIT = 0;
  localparam int unsigned BPCTRL_EN_BIT   = 1;
  localparam int unsigned BPCTRL_CC_LSB   = 4;
  localparam int unsigned BPCTRL_CC_W     = 3;

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // Breakpoint n occupies a pair of offsets
  function automatic du_addr_t bp_ctrl_addr(int unsigned n);
    return du_addr_t'(DU_BPCTRL0 + 2 * n);
  endfunction

  function automatic du_addr_t bp_data_addr(int unsigned n);
    return du_addr_t'(DU_BPDATA0 + 2 * n);
  endfunction

endpackage

`default_nettype wire

// File: hw/du_reg_if.sv
// Debug register access interface
`default_nettype none

interface du_reg_if #(
  parameter int unsigned ADDR_W = 8,
  parameter int unsigned DATA_W = 32
);

  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  // Combinational from addr
  logic [DATA_W-1:0] rdata;

  modport bus (
    output we, addr, wdata,
    input  rdata
  );

  modport regs (
    input  we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: hw/du_bus_slave.sv
// Debug port Wishbone slave
`default_nettype none

module du_bus_slave
  import du_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  du_addr_t wb_adr_i,
  input  du_word_t wb_dat_i,
  output du_word_t wb_dat_o,
  output logic     wb_ack_o,
  du_reg_if.bus    reg_if
);

  logic access;

  // A held strobe is served every second cycle
  assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  // Write lands on the edge that raises ack
  assign reg_if.we    = access & wb_we_i;
  assign reg_if.addr  = wb_adr_i;
  assign reg_if.wdata = wb_dat_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_ack_o <= 1'b0;
    else
      wb_ack_o <= access;
  end

  // Read data valid while ack is high
  always_ff @(posedge clk_i)
  begin
    if (access)
      wb_dat_o <= reg_if.rdata;
  end

  ack_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) wb_ack_o |=> !wb_ack_o
  ) else $error("Wishbone ack held for two cycles");

endmodule

`default_nettype wire

// File: hw/du_regs.sv
// Debug unit register file
`default_nettype none

module du_regs
  import du_pkg::*;
#(
  parameter int unsigned BREAKPOINTS = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       step_hit_i,
  input  logic                       branch_hit_i,
  input  logic [MAX_BREAKPOINTS-1:0] bp_hit_i,
  input  logic [EXC_W-1:0]           exc_i,
  input  du_word_t                   cause_i,
  input  logic                       du_flush_i,
  output logic                       ctrl_step_o,
  output logic                       ctrl_branch_o,
  output logic [MAX_BREAKPOINTS-1:0] bp_en_o,
  output bp_cc_t                     bp_cc_o [MAX_BREAKPOINTS],
  output du_word_t                   bp_data_o [MAX_BREAKPOINTS],
  output logic                       hit_any_o,
  output logic [EXC_W-1:0]           du_ie_o,
  du_reg_if.regs                     reg_if
);

  // Hit bits of implemented breakpoints only
  localparam logic [MAX_BREAKPOINTS-1:0] BP_MASK = MAX_BREAKPOINTS'((1 << BREAKPOINTS) - 1);

  logic                       ctrl_step_q, ctrl_branch_q;
  logic                       hit_step_q, hit_branch_q;
  logic [MAX_BREAKPOINTS-1:0] hit_bp_q;
  logic [EXC_W-1:0]           ie_q;
  du_word_t                   cause_q;
  logic [MAX_BREAKPOINTS-1:0] bp_en_q;
  bp_cc_t                     bp_cc_q [MAX_BREAKPOINTS];
  du_word_t                   bp_data_q [MAX_BREAKPOINTS];
  logic                       wr_ctrl, wr_hit, wr_ie, wr_cause;
  du_word_t                   rdata_c;

  assign wr_ctrl  = reg_if.we && reg_if.addr == DU_CTRL;
  assign wr_hit   = reg_if.we && reg_if.addr == DU_HIT;
  assign wr_ie    = reg_if.we && reg_if.addr == DU_IE;
  assign wr_cause = reg_if.we && reg_if.addr == DU_CAUSE;

  ////////////////////////////////////////////////////////////////////////////
  // Control, hit, enable and cause
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ctrl_step_q   <= 1'b0;
      ctrl_branch_q <= 1'b0;
      hit_step_q    <= 1'b0;
      hit_branch_q  <= 1'b0;
      hit_bp_q      <= '0;
      ie_q          <= '0;
      cause_q       <= '0;
    end
    else
    begin
      if (wr_ctrl)
      begin
        ctrl_step_q   <= reg_if.wdata[CTRL_STEP_BIT];
        ctrl_branch_q <= reg_if.wdata[CTRL_BRANCH_BIT];
      end
      // Sticky hits, a bus write wins over new events
      if (wr_hit)
      begin
        hit_step_q   <= reg_if.wdata[HIT_STEP_BIT];
        hit_branch_q <= reg_if.wdata[HIT_BRANCH_BIT];
        hit_bp_q     <= reg_if.wdata[HIT_BP_LSB +: MAX_BREAKPOINTS] & BP_MASK;
      end
      else
      begin
        hit_step_q   <= hit_step_q | step_hit_i;
        hit_branch_q <= hit_branch_q | branch_hit_i;
        hit_bp_q     <= hit_bp_q | bp_hit_i;
      end
      if (wr_ie)
        ie_q <= reg_if.wdata[EXC_W-1:0];
      if (wr_cause)
        cause_q <= reg_if.wdata;
      else if (du_flush_i && exc_i == '0)
        cause_q <= '0;
      else if (exc_i != '0)
        cause_q <= cause_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Breakpoint control and data
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int unsigned n = 0; n < MAX_BREAKPOINTS; n++)
      begin
        bp_en_q[n]   <= 1'b0;
        bp_cc_q[n]   <= BP_CC_FETCH;
        bp_data_q[n] <= '0;
      end
    end
    else
    begin
      // Unimplemented slots ignore writes and stay zero
      for (int unsigned n = 0; n < BREAKPOINTS; n++)
      begin
        if (reg_if.we && reg_if.addr == bp_ctrl_addr(n))
        begin
          bp_en_q[n] <= reg_if.wdata[BPCTRL_EN_BIT];
          bp_cc_q[n] <= bp_cc_t'(reg_if.wdata[BPCTRL_CC_LSB +: BPCTRL_CC_W]);
        end
        if (reg_if.we && reg_if.addr == bp_data_addr(n))
          bp_data_q[n] <= reg_if.wdata;
      end
    end
  end

  // Read multiplexer
  always_comb
  begin
    rdata_c = '0;
    case (reg_if.addr)
      DU_CTRL:
      begin
        rdata_c[CTRL_STEP_BIT]   = ctrl_step_q;
        rdata_c[CTRL_BRANCH_BIT] = ctrl_branch_q;
      end
      DU_HIT:
      begin
        rdata_c[HIT_STEP_BIT]                   = hit_step_q;
        rdata_c[HIT_BRANCH_BIT]                 = hit_branch_q;
        rdata_c[HIT_BP_LSB +: MAX_BREAKPOINTS]  = hit_bp_q;
      end
      DU_IE:    rdata_c = du_word_t'(ie_q);
      DU_CAUSE: rdata_c = cause_q;
      default:  rdata_c = '0;
    endcase
    for (int unsigned n = 0; n < BREAKPOINTS; n++)
    begin
      if (reg_if.addr == bp_ctrl_addr(n))
      begin
        rdata_c[BPCTRL_IMPL_BIT]                    = 1'b1;
        rdata_c[BPCTRL_EN_BIT]                      = bp_en_q[n];
        rdata_c[BPCTRL_CC_LSB +: BPCTRL_CC_W]       = bp_cc_q[n];
      end
      if (reg_if.addr == bp_data_addr(n))
        rdata_c = bp_data_q[n];
    end
  end

  assign reg_if.rdata  = rdata_c;
  assign ctrl_step_o   = ctrl_step_q;
  assign ctrl_branch_o = ctrl_branch_q;
  assign bp_en_o       = bp_en_q;
  assign bp_cc_o       = bp_cc_q;
  assign bp_data_o     = bp_data_q;
  assign hit_any_o     = hit_step_q | hit_branch_q | (|hit_bp_q);
  assign du_ie_o       = ie_q;

  no_unimplemented_hit: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (hit_bp_q & ~BP_MASK) == '0
  ) else $error("Hit bit set for an unimplemented breakpoint");

endmodule

`default_nettype wire

// File: hw/du_bp_match.sv
// Breakpoint and break condition detection
`default_nettype none

module du_bp_match
  import du_pkg::*;
#(
  parameter int unsigned BREAKPOINTS = 3
) (
  input  logic                       ctrl_step_i,
  input  logic                       ctrl_branch_i,
  input  logic [MAX_BREAKPOINTS-1:0] bp_en_i,
  input  bp_cc_t                     bp_cc_i [MAX_BREAKPOINTS],
  input  du_word_t                   bp_data_i [MAX_BREAKPOINTS],
  input  logic                       fetch_valid_i,
  input  du_word_t                   if_insn_i,
  input  logic                       pd_valid_i,
  input  du_word_t                   pd_pc_i,
  input  logic                       mem_valid_i,
  input  logic                       mem_we_i,
  input  du_word_t                   mem_adr_i,
  input  logic                       flush_i,
  output logic                       step_hit_o,
  output logic                       branch_hit_o,
  output logic [MAX_BREAKPOINTS-1:0] bp_hit_o
);

  assign step_hit_o   = ctrl_step_i & fetch_valid_i;
  assign branch_hit_o = ctrl_branch_i & fetch_valid_i & (if_insn_i[6:0] == OPC_BRANCH);

  always_comb
  begin
    bp_hit_o = '0;
    for (int unsigned n = 0; n < BREAKPOINTS; n++)
    begin
      if (bp_en_i[n])
      begin
        case (bp_cc_i[n])
          // Fetch match is lost when the pipeline flushes
          BP_CC_FETCH:    bp_hit_o[n] = pd_valid_i & ~flush_i & (pd_pc_i == bp_data_i[n]);
          BP_CC_LD_ADR:   bp_hit_o[n] = mem_valid_i & ~mem_we_i & (mem_adr_i == bp_data_i[n]);
          BP_CC_ST_ADR:   bp_hit_o[n] = mem_valid_i & mem_we_i & (mem_adr_i == bp_data_i[n]);
          BP_CC_LDST_ADR: bp_hit_o[n] = mem_valid_i & (mem_adr_i == bp_data_i[n]);
          default:        bp_hit_o[n] = 1'b0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/du_cause_enc.sv
// Exception cause encoder
`default_nettype none

module du_cause_enc
  import du_pkg::*;
(
  input  logic [EXC_W-1:0] exc_i,
  output du_word_t         cause_o
);

  // Lowest set bit wins, traps before interrupts
  always_comb
  begin
    cause_o = '0;
    if (|exc_i[EXC_TRAP_W-1:0])
    begin
      for (int i = EXC_TRAP_W - 1; i >= 0; i--)
        if (exc_i[i])
          cause_o = du_word_t'(i);
    end
    else if (|exc_i[EXC_W-1:EXC_TRAP_W])
    begin
      for (int i = EXC_W - 1; i >= EXC_TRAP_W; i--)
        if (exc_i[i])
          cause_o = du_word_t'(i - EXC_TRAP_W);
      // Interrupt flag
      cause_o[XLEN-1] = 1'b1;
    end
  end

  // Cause must name a bit that is actually set
  always_comb
  begin
    if (exc_i != '0)
      assert (exc_i[cause_o[XLEN-1] ? EXC_TRAP_W + cause_o[3:0] : cause_o[3:0]])
        else $error("Cause does not point at a set exception bit");
  end

endmodule

`default_nettype wire

// File: hw/du_halt_ctrl.sv
// Debug halt and resume control
`default_nettype none

module du_halt_ctrl
  import du_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             dbg_stall_i,
  input  logic             flush_i,
  input  logic             hit_any_i,
  input  logic [EXC_W-1:0] exc_i,
  output logic             dbg_bp_o,
  output logic             du_stall_o,
  output logic             du_stall_if_o,
  output logic             du_flush_o
);

  logic stall_dly_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      stall_dly_q <= 1'b0;
    else
      stall_dly_q <= dbg_stall_i;
  end

  // Flush once on leaving debug, memory may have been changed
  assign du_flush_o    = ~dbg_stall_i & stall_dly_q;
  assign du_stall_o    = dbg_stall_i;
  assign du_stall_if_o = dbg_stall_i | hit_any_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dbg_bp_o <= 1'b0;
    else
      dbg_bp_o <= (hit_any_i | (|exc_i)) & ~flush_i & ~du_flush_o;
  end

endmodule

`default_nettype wire

// File: hw/du_top.sv
// Debug unit top level
`default_nettype none

module du_top
  import du_pkg::*;
#(
  parameter int unsigned BREAKPOINTS = 3
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Wishbone debug port
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  du_addr_t         wb_adr_i,
  input  du_word_t         wb_dat_i,
  output du_word_t         wb_dat_o,
  output logic             wb_ack_o,
  // CPU side
  input  logic             dbg_stall_i,
  input  logic             flush_i,
  input  logic             fetch_valid_i,
  input  du_word_t         if_insn_i,
  input  logic             pd_valid_i,
  input  du_word_t         pd_pc_i,
  input  logic             mem_valid_i,
  input  logic             mem_we_i,
  input  du_word_t         mem_adr_i,
  input  logic [EXC_W-1:0] exc_i,
  output logic             dbg_bp_o,
  output logic             du_stall_o,
  output logic             du_stall_if_o,
  output logic             du_flush_o,
  output logic [EXC_W-1:0] du_ie_o
);

  logic                       ctrl_step, ctrl_branch;
  logic                       step_hit, branch_hit, hit_any;
  logic [MAX_BREAKPOINTS-1:0] bp_en, bp_hit;
  bp_cc_t                     bp_cc [MAX_BREAKPOINTS];
  du_word_t                   bp_data [MAX_BREAKPOINTS];
  du_word_t                   cause;

  du_reg_if #(.ADDR_W(DU_ADDR_W), .DATA_W(XLEN)) u_reg_if ();

  du_bus_slave u_bus_slave (
    .clk_i, .rst_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o,
    .reg_if   (u_reg_if.bus)
  );

  du_regs #(.BREAKPOINTS(BREAKPOINTS)) u_regs (
    .clk_i, .rst_ni,
    .step_hit_i    (step_hit),
    .branch_hit_i  (branch_hit),
    .bp_hit_i      (bp_hit),
    .exc_i,
    .cause_i       (cause),
    .du_flush_i    (du_flush_o),
    .ctrl_step_o   (ctrl_step),
    .ctrl_branch_o (ctrl_branch),
    .bp_en_o       (bp_en),
    .bp_cc_o       (bp_cc),
    .bp_data_o     (bp_data),
    .hit_any_o     (hit_any),
    .du_ie_o,
    .reg_if        (u_reg_if.regs)
  );

  du_bp_match #(.BREAKPOINTS(BREAKPOINTS)) u_bp_match (
    .ctrl_step_i   (ctrl_step),
    .ctrl_branch_i (ctrl_branch),
    .bp_en_i       (bp_en),
    .bp_cc_i       (bp_cc),
    .bp_data_i     (bp_data),
    .fetch_valid_i, .if_insn_i, .pd_valid_i, .pd_pc_i,
    .mem_valid_i, .mem_we_i, .mem_adr_i, .flush_i,
    .step_hit_o    (step_hit),
    .branch_hit_o  (branch_hit),
    .bp_hit_o      (bp_hit)
  );

  du_cause_enc u_cause_enc (
    .exc_i,
    .cause_o (cause)
  );

  du_halt_ctrl u_halt_ctrl (
    .clk_i, .rst_ni, .dbg_stall_i, .flush_i,
    .hit_any_i (hit_any),
    .exc_i,
    .dbg_bp_o, .du_stall_o, .du_stall_if_o, .du_flush_o
  );

endmodule

`default_nettype wire

// File: tb/tb_du.sv
// Debug unit testbench
`default_nettype none

module tb_du
  import du_pkg::*;
;

  localparam int BREAKPOINTS    = 3;
  localparam int NUM_ITER       = 40;
  localparam int ACK_WAIT_MAX   = 8;
  localparam int PLANNED_CYCLES = 1100 + 54 * NUM_ITER;
  localparam int TIMEOUT_CYCLES = 4 * PLANNED_CYCLES;
  localparam logic [31:0] SEED  = 32'h8913;

  logic             clk, rst_n;
  logic             wb_cyc, wb_stb, wb_we, wb_ack;
  du_addr_t         wb_adr;
  du_word_t         wb_dat_w, wb_dat_r;
  logic             dbg_stall, flush, fetch_valid, pd_valid, mem_valid, mem_we;
  du_word_t         if_insn, pd_pc, mem_adr;
  logic [EXC_W-1:0] exc, du_ie;
  logic             dbg_bp, du_stall, du_stall_if, du_flush;

  // Reference model state
  logic                       m_ctrl_step, m_ctrl_branch, m_hit_step, m_hit_branch;
  logic [MAX_BREAKPOINTS-1:0] m_hit_bp, m_bp_en;
  logic [2:0]                 m_bp_cc [MAX_BREAKPOINTS];
  du_word_t                   m_bp_data [MAX_BREAKPOINTS];
  logic [EXC_W-1:0]           m_ie;
  du_word_t                   m_cause, m_rdata;
  logic                       m_ack, m_stall_dly, m_dbg_bp;

  int       errors, checks, cycles;

  du_top #(.BREAKPOINTS(BREAKPOINTS)) u_dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_we_i       (wb_we),
    .wb_adr_i      (wb_adr),
    .wb_dat_i      (wb_dat_w),
    .wb_dat_o      (wb_dat_r),
    .wb_ack_o      (wb_ack),
    .dbg_stall_i   (dbg_stall),
    .flush_i       (flush),
    .fetch_valid_i (fetch_valid),
    .if_insn_i     (if_insn),
    .pd_valid_i    (pd_valid),
    .pd_pc_i       (pd_pc),
    .mem_valid_i   (mem_valid),
    .mem_we_i      (mem_we),
    .mem_adr_i     (mem_adr),
    .exc_i         (exc),
    .dbg_bp_o      (dbg_bp),
    .du_stall_o    (du_stall),
    .du_stall_if_o (du_stall_if),
    .du_flush_o    (du_flush),
    .du_ie_o       (du_ie)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
    cycles <= cycles + 1;

  initial
  begin : watchdog
    wait (cycles >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_word(input du_word_t got, input du_word_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s got 0x%h expected 0x%h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic du_addr_t ctrl_offset(int n);
    return du_addr_t'(int'(DU_BPCTRL0) + 2 * n);
  endfunction

  function automatic du_addr_t data_offset(int n);
    return du_addr_t'(int'(DU_BPDATA0) + 2 * n);
  endfunction

  function automatic logic any_hit_set();
    return m_hit_step | m_hit_branch | (|m_hit_bp);
  endfunction

  // Lowest trap first, then lowest interrupt with the flag in the top bit
  function automatic du_word_t ref_cause(logic [EXC_W-1:0] e);
    du_word_t c;
    logic     found;
    c = '0;
    found = 1'b0;
    for (int i = 0; i < EXC_TRAP_W; i++)
      if (!found && e[i])
      begin
        c = du_word_t'(i);
        found = 1'b1;
      end
    for (int i = EXC_TRAP_W; i < EXC_W; i++)
      if (!found && e[i])
      begin
        c = du_word_t'(i - EXC_TRAP_W);
        c[XLEN-1] = 1'b1;
        found = 1'b1;
      end
    return c;
  endfunction

  function automatic du_word_t expected_read(du_addr_t a);
    du_word_t r;
    r = '0;
    if (a == DU_CTRL)
    begin
      r[CTRL_STEP_BIT]   = m_ctrl_step;
      r[CTRL_BRANCH_BIT] = m_ctrl_branch;
    end
    else if (a == DU_HIT)
    begin
      r[HIT_STEP_BIT]                  = m_hit_step;
      r[HIT_BRANCH_BIT]                = m_hit_branch;
      r[HIT_BP_LSB +: MAX_BREAKPOINTS] = m_hit_bp;
    end
    else if (a == DU_IE)
      r = m_ie;
    else if (a == DU_CAUSE)
      r = m_cause;
    for (int n = 0; n < BREAKPOINTS; n++)
    begin
      if (a == ctrl_offset(n))
      begin
        r[BPCTRL_IMPL_BIT]                = 1'b1;
        r[BPCTRL_EN_BIT]                  = m_bp_en[n];
        r[BPCTRL_CC_LSB +: BPCTRL_CC_W]   = m_bp_cc[n];
      end
      if (a == data_offset(n))
        r = m_bp_data[n];
    end
    return r;
  endfunction

  function automatic void apply_write(du_addr_t a, du_word_t d);
    if (a == DU_CTRL)
    begin
      m_ctrl_step   = d[CTRL_STEP_BIT];
      m_ctrl_branch = d[CTRL_BRANCH_BIT];
    end
    if (a == DU_HIT)
    begin
      m_hit_step   = d[HIT_STEP_BIT];
      m_hit_branch = d[HIT_BRANCH_BIT];
      m_hit_bp     = '0;
      for (int n = 0; n < BREAKPOINTS; n++)
        m_hit_bp[n] = d[HIT_BP_LSB + n];
    end
    if (a == DU_IE)
      m_ie = d;
    if (a == DU_CAUSE)
      m_cause = d;
    for (int n = 0; n < BREAKPOINTS; n++)
    begin
      if (a == ctrl_offset(n))
      begin
        m_bp_en[n] = d[BPCTRL_EN_BIT];
        m_bp_cc[n] = d[BPCTRL_CC_LSB +: BPCTRL_CC_W];
      end
      if (a == data_offset(n))
        m_bp_data[n] = d;
    end
  endfunction

  function automatic logic [MAX_BREAKPOINTS-1:0] predicted_bp_hits();
    logic [MAX_BREAKPOINTS-1:0] h;
    logic                       adr_eq;
    h = '0;
    for (int n = 0; n < BREAKPOINTS; n++)
    begin
      adr_eq = mem_adr == m_bp_data[n];
      if (m_bp_en[n])
        case (m_bp_cc[n])
          BP_CC_FETCH:    h[n] = pd_valid & ~flush & (pd_pc == m_bp_data[n]);
          BP_CC_LD_ADR:   h[n] = mem_valid & ~mem_we & adr_eq;
          BP_CC_ST_ADR:   h[n] = mem_valid & mem_we & adr_eq;
          BP_CC_LDST_ADR: h[n] = mem_valid & adr_eq;
          default:        h[n] = 1'b0;
        endcase
    end
    return h;
  endfunction

  // Outputs compared every cycle, after the inputs have settled
  task automatic check_outputs();
    check_bit(wb_ack, m_ack, "wb_ack_o");
    if (m_ack)
      check_word(wb_dat_r, m_rdata, "wb_dat_o");
    check_bit(dbg_bp, m_dbg_bp, "dbg_bp_o");
    check_bit(du_stall, dbg_stall, "du_stall_o");
    check_bit(du_stall_if, dbg_stall | any_hit_set(), "du_stall_if_o");
    check_bit(du_flush, ~dbg_stall & m_stall_dly, "du_flush_o");
    check_word(du_ie, m_ie, "du_ie_o");
  endtask

  // One clock: check, advance the model, then return just after the edge
  task automatic tick();
    logic                       access, flush_pulse, hits_before;
    logic [MAX_BREAKPOINTS-1:0] bp_hit;
    #1;
    check_outputs();
    access      = wb_cyc & wb_stb & ~m_ack;
    flush_pulse = ~dbg_stall & m_stall_dly;
    hits_before = any_hit_set();
    bp_hit      = predicted_bp_hits();
    m_dbg_bp    = (hits_before | (|exc)) & ~flush & ~flush_pulse;
    m_stall_dly = dbg_stall;
    if (access)
      m_rdata = expected_read(wb_adr);
    m_ack = access;
    m_hit_step   = m_hit_step | (m_ctrl_step & fetch_valid);
    m_hit_branch = m_hit_branch | (m_ctrl_branch & fetch_valid & (if_insn[6:0] == OPC_BRANCH));
    m_hit_bp     = m_hit_bp | bp_hit;
    if (exc != '0)
      m_cause = ref_cause(exc);
    else if (flush_pulse)
      m_cause = '0;
    // Bus write wins over events
    if (access && wb_we)
      apply_write(wb_adr, wb_dat_w);
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic bus_access(input logic we, input du_addr_t adr, input du_word_t wdat,
                            output du_word_t rdat);
    int waits;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waits    = 0;
    tick();
    while (!wb_ack && waits < ACK_WAIT_MAX)
    begin
      tick();
      waits++;
    end
    if (!wb_ack)
    begin
      errors++;
      $display("No Wishbone acknowledge for offset 0x%h at time %0t", adr, $time);
    end
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    tick();
  endtask

  task automatic bus_write(input du_addr_t adr, input du_word_t d);
    du_word_t unused;
    bus_access(1'b1, adr, d, unused);
  endtask

  task automatic bus_read(input du_addr_t adr, output du_word_t d);
    bus_access(1'b0, adr, '0, d);
  endtask

  task automatic clear_regs();
    bus_write(DU_CTRL, '0);
    bus_write(DU_HIT, '0);
    bus_write(DU_IE, '0);
    bus_write(DU_CAUSE, '0);
    for (int n = 0; n < MAX_BREAKPOINTS; n++)
    begin
      bus_write(ctrl_offset(n), '0);
      bus_write(data_offset(n), '0);
    end
  endtask

  function automatic du_word_t bp_ctrl_word(logic en, bp_cc_t cc);
    du_word_t w;
    w = '0;
    w[BPCTRL_EN_BIT]                = en;
    w[BPCTRL_CC_LSB +: BPCTRL_CC_W] = cc;
    return w;
  endfunction

  function automatic logic rand_bit();
    du_word_t r;
    r = $urandom;
    return r[0];
  endfunction

  // Few bits set, sometimes interrupts only
  function automatic logic [EXC_W-1:0] sparse_vector();
    logic [EXC_W-1:0] v;
    du_word_t         pick;
    v    = $urandom & $urandom & $urandom;
    pick = $urandom;
    if (pick[1:0] == 2'd0)
      v[EXC_TRAP_W-1:0] = '0;
    if (v == '0)
      v[pick[4:0]] = 1'b1;
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin : main
    du_word_t         rd, pc, d;
    du_word_t         adrs [BREAKPOINTS];
    logic             fl, miss, hit_exp, fv, present;
    logic [EXC_W-1:0] e;
    int               n, len;

    void'($urandom(SEED));
    errors = 0;
    checks = 0;
    cycles = 0;
    {rst_n, wb_cyc, wb_stb, wb_we, dbg_stall, flush, fetch_valid} = '0;
    {pd_valid, mem_valid, mem_we} = '0;
    wb_adr = '0;
    {wb_dat_w, if_insn, pd_pc, mem_adr, exc} = '0;
    {m_ctrl_step, m_ctrl_branch, m_hit_step, m_hit_branch, m_ack, m_stall_dly, m_dbg_bp} = '0;
    {m_hit_bp, m_bp_en, m_ie, m_cause, m_rdata} = '0;
    for (int i = 0; i < MAX_BREAKPOINTS; i++)
    begin
      m_bp_cc[i]   = '0;
      m_bp_data[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Register window, every offset
    for (int a = 0; a < (1 << DU_ADDR_W); a++)
    begin
      bus_write(du_addr_t'(a), $urandom);
      d = expected_read(du_addr_t'(a));
      bus_read(du_addr_t'(a), rd);
      check_word(rd, d, "register readback");
    end
    clear_regs();

    // Fetch breakpoint, with and without flush
    repeat (NUM_ITER)
    begin
      n    = $urandom % BREAKPOINTS;
      pc   = $urandom;
      fl   = ($urandom % 4) == 0;
      miss = ($urandom % 4) == 0;
      bus_write(ctrl_offset(n), bp_ctrl_word(1'b1, BP_CC_FETCH));
      bus_write(data_offset(n), pc);
      hit_exp  = !fl && !miss;
      pd_valid = 1'b1;
      pd_pc    = miss ? pc ^ (32'h1 << ($urandom % 32)) : pc;
      flush    = fl;
      tick();
      pd_valid = 1'b0;
      flush    = 1'b0;
      check_bit(dbg_bp, 1'b0, "dbg_bp_o one cycle after fetch event");
      tick();
      check_bit(dbg_bp, hit_exp, "dbg_bp_o two cycles after fetch event");
      bus_read(DU_HIT, rd);
      check_bit(rd[HIT_BP_LSB + n], hit_exp, "fetch breakpoint hit bit");
      bus_write(ctrl_offset(n), '0);
      bus_write(DU_HIT, '0);
    end

    // Memory address breakpoints
    for (int i = 0; i < BREAKPOINTS; i++)
      adrs[i] = $urandom;
    bus_write(ctrl_offset(0), bp_ctrl_word(1'b1, BP_CC_LD_ADR));
    bus_write(ctrl_offset(1), bp_ctrl_word(1'b1, BP_CC_ST_ADR));
    bus_write(ctrl_offset(2), bp_ctrl_word(1'b1, BP_CC_LDST_ADR));
    for (int i = 0; i < BREAKPOINTS; i++)
      bus_write(data_offset(i), adrs[i]);
    repeat (NUM_ITER)
    begin
      n         = $urandom % 4;
      mem_adr   = (n < BREAKPOINTS) ? adrs[n] : $urandom;
      mem_we    = rand_bit();
      mem_valid = ($urandom % 8) != 0;
      tick();
      bus_read(DU_HIT, rd);
      check_bit(rd[HIT_BP_LSB], mem_valid & ~mem_we & (mem_adr == adrs[0]), "load hit");
      check_bit(rd[HIT_BP_LSB + 1], mem_valid & mem_we & (mem_adr == adrs[1]), "store hit");
      check_bit(rd[HIT_BP_LSB + 2], mem_valid & (mem_adr == adrs[2]), "load or store hit");
      mem_valid = 1'b0;
      bus_write(DU_HIT, '0);
      bus_read(DU_HIT, rd);
      check_word(rd, '0, "HIT after clear");
    end
    clear_regs();

    // Single step and branch break
    repeat (NUM_ITER)
    begin
      d = '0;
      d[CTRL_STEP_BIT]   = rand_bit();
      d[CTRL_BRANCH_BIT] = rand_bit();
      bus_write(DU_CTRL, d);
      fv = rand_bit();
      if_insn = $urandom;
      if (rand_bit())
        if_insn[6:0] = OPC_BRANCH;
      fetch_valid = fv;
      tick();
      fetch_valid = 1'b0;
      hit_exp = d[CTRL_BRANCH_BIT] & fv & (if_insn[6:0] == OPC_BRANCH);
      check_bit(du_stall_if, (d[CTRL_STEP_BIT] & fv) | hit_exp, "du_stall_if_o after event");
      bus_read(DU_HIT, rd);
      check_bit(rd[HIT_STEP_BIT], d[CTRL_STEP_BIT] & fv, "step hit");
      check_bit(rd[HIT_BRANCH_BIT], hit_exp, "branch hit");
      bus_write(DU_CTRL, '0);
      bus_write(DU_HIT, '0);
    end

    // Exceptions into CAUSE
    repeat (NUM_ITER)
    begin
      e = sparse_vector();
      check_bit(dbg_bp, 1'b0, "dbg_bp_o before exception");
      exc = e;
      tick();
      check_bit(dbg_bp, 1'b1, "dbg_bp_o one cycle after exception");
      exc = '0;
      tick();
      bus_read(DU_CAUSE, rd);
      check_word(rd, ref_cause(e), "CAUSE after exception");
    end

    // Stall, resume flush and interrupt enable
    d = $urandom;
    bus_write(DU_IE, d);
    check_word(du_ie, d, "du_ie_o after IE write");
    repeat (NUM_ITER)
    begin
      exc = sparse_vector();
      tick();
      exc = '0;
      dbg_stall = 1'b1;
      len = 1 + $urandom % 4;
      repeat (len) tick();
      check_bit(du_stall, 1'b1, "du_stall_o while stalled");
      dbg_stall = 1'b0;
      present = rand_bit();
      e = sparse_vector();
      exc = present ? e : '0;
      #1;
      check_bit(du_flush, 1'b1, "du_flush_o after stall falls");
      check_bit(du_stall, 1'b0, "du_stall_o after stall falls");
      tick();
      check_bit(du_flush, 1'b0, "du_flush_o single pulse");
      exc = '0;
      bus_read(DU_CAUSE, rd);
      check_word(rd, present ? ref_cause(e) : '0, "CAUSE after resume flush");
    end
    tick();

    $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hw/du_pkg.sv
hw/du_reg_if.sv
hw/du_bus_slave.sv
hw/du_regs.sv
hw/du_bp_match.sv
hw/du_cause_enc.sv
hw/du_halt_ctrl.sv
hw/du_top.sv
tb/tb_du.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the debug unit testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_du -f flist.f -o tb_du &&
  ./obj_dir/tb_du | tee /dev/stderr | grep -qxF "=== PASS ===" &&
  echo "Result: passed" ||
  { echo "Result: failed"; exit 1; }
